//--- bench/ds_tests.txt
# Each line: op, then eight hex fields; unused fields are 0
# runstop: port preamble0 value exp_run exp_wide
# cmd: port broadcast ctrl word exp_addr exp_word exp_alt exp_cnt_toggles
# data: port ctrl cw exp_lr_beats exp_lr_last exp_iq_beats exp_iq_last exp_cnt_toggles
# flash: port count exp_beats exp_last exp_flash_cnt
# erase: port ack_delay / keyer: addr word / msec: pulses / wdog: pulses exp_run
# disc: port exp_toggles exp_discover_port
runstop 400 ef 03 1 1 0 0 0
runstop 400 ef 00 0 0 0 0 0
runstop 400 ef 01 1 0 0 0 0
runstop 400 ee 00 1 0 0 0 0
runstop 600 ef 00 1 0 0 0 0
runstop 401 ef 00 0 0 0 0 0
cmd 401 0 8a 12345678 05 12345678 1 1
cmd 401 1 20 deadbeef 05 12345678 1 0
cmd 400 0 20 deadbeef 05 12345678 1 0
data 400 01 0 1f8 7e 1f8 7e 2
data 400 00 0 1f8 7e 0 0 2
keyer 0f 01000000 0 0 0 0 0 0
data 400 00 1 1f8 7e 1f4 7d 2
msec 1f3 0 0 0 0 0 0 0
data 400 00 0 1f8 7e 1f8 7e 2
msec 1 0 0 0 0 0 0 0
data 400 00 0 1f8 7e 0 0 2
flash 400 1234 100 1 1234 0 0 0
erase 400 23 0 0 0 0 0 0
runstop 400 ef 01 1 0 0 0 0
wdog 3fe 1 0 0 0 0 0 0
wdog 1 0 0 0 0 0 0 0
disc 401 1 1 0 0 0 0 0
disc 400 1 0 0 0 0 0 0

//--- verilog.f
design/hpsdr_pkg.sv
design/hpsdr_ifs.sv
design/ds_parser.sv
design/cmd_assembler.sv
design/link_supervisor.sv
design/hpsdr_ds_top.sv
bench/hpsdr_ds_props.sv
bench/tb_hpsdr_ds.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_hpsdr_ds
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --assert -j 0
PASS_TEXT ?= Testbench passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

//--- bench/tb_hpsdr_ds.sv
// Testbench for the downstream unpacker with file-driven packets, stream counters, checks and report
`timescale 1ns/1ps

module tb_hpsdr_ds;
  import hpsdr_pkg::*;

  localparam int    CLK_HALF  = 10;
  localparam int    MAX_TESTS = 64;
  localparam string TEST_FILE = "bench/ds_tests.txt";

  // Counter slots
  localparam int C_LRV = 0;
  localparam int C_LRL = 1;
  localparam int C_IQV = 2;
  localparam int C_IQL = 3;
  localparam int C_FLV = 4;
  localparam int C_FLL = 5;
  localparam int C_CMD = 6;
  localparam int C_DSC = 7;
  localparam int C_IQU = 8;

  logic                   clk = 1'b0;
  logic                   rst;
  logic [15:0]            eth_port;
  logic                   eth_broadcast;
  logic                   eth_valid;
  logic [7:0]             eth_data;
  logic                   eth_unreachable;
  logic                   watchdog_up;
  logic                   msec_pulse;
  logic                   flash_erase_ack;
  logic [CMD_ADDR_W-1:0]  cmd_addr;
  logic [CMD_DATA_W-1:0]  cmd_data;
  logic                   cmd_rqst;
  logic                   run;
  logic                   wide_spectrum;
  logic                   discover_port;
  logic                   discover_cnt;
  logic [CMD_ADDR_W-1:0]  ds_cmd_addr;
  logic [CMD_DATA_W-1:0]  ds_cmd_data;
  logic                   ds_cmd_cnt;
  logic                   ds_cmd_resprqst;
  logic                   ds_cmd_is_alt;
  logic [7:0]             ds_tdata;
  logic                   iq_valid;
  logic                   iq_last;
  logic                   iq_user;
  logic                   lr_valid;
  logic                   lr_last;
  logic                   flash_valid;
  logic                   flash_last;
  logic [FLASH_CNT_W-1:0] flash_cnt;
  logic                   flash_erase;

  logic [63:0] test_op [MAX_TESTS];
  logic [31:0] test_arg [MAX_TESTS][8];
  int          num_tests;
  int          total_bytes;
  int          pulse_tests;
  int          limit_cycles = 0;
  int          errors = 0;
  int          checks = 0;
  int          cnt [9];
  int          base [9];
  logic        cmd_cnt_q;
  logic        disc_cnt_q;
  logic        exp_resprqst = 1'b0;
  logic        prev_cw = 1'b0;
  logic [7:0]  pkt_q [$];

  hpsdr_ds_top dut0 (.*);

  always #CLK_HALF clk = ~clk;

  // Beat and toggle counters
  always @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 9; i++) cnt[i] <= 0;
      cmd_cnt_q  <= 1'b0;
      disc_cnt_q <= 1'b0;
    end else begin
      if (lr_valid) cnt[C_LRV] <= cnt[C_LRV] + 1;
      if (lr_last) cnt[C_LRL] <= cnt[C_LRL] + 1;
      if (iq_valid) cnt[C_IQV] <= cnt[C_IQV] + 1;
      if (iq_last) cnt[C_IQL] <= cnt[C_IQL] + 1;
      if (iq_valid && iq_user) cnt[C_IQU] <= cnt[C_IQU] + 1;
      if (flash_valid) cnt[C_FLV] <= cnt[C_FLV] + 1;
      if (flash_last) cnt[C_FLL] <= cnt[C_FLL] + 1;
      if (ds_cmd_cnt != cmd_cnt_q) cnt[C_CMD] <= cnt[C_CMD] + 1;
      if (discover_cnt != disc_cnt_q) cnt[C_DSC] <= cnt[C_DSC] + 1;
      cmd_cnt_q  <= ds_cmd_cnt;
      disc_cnt_q <= discover_cnt;
    end
  end

  initial begin
    wait (limit_cycles > 0);
    repeat (limit_cycles) @(posedge clk);
    $display("Timeout: tests did not finish within %0d cycles", limit_cycles);
    $display("Testbench failed");
    $finish;
  end

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("CHECK FAILED at %0t ns: %s = %0h, expected %0h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic put(input logic [7:0] b);
    pkt_q.push_back(b);
  endtask

  function automatic int packet_bytes(input logic [63:0] op);
    case (op)
      64'("data"):  return 1032;
      64'("flash"): return 264;
      64'("cmd"):   return 8;
      default:      return 4;
    endcase
  endfunction

  task automatic load_tests();
    int          fd;
    int          rc;
    int          ch;
    logic [63:0] tok;
    logic [31:0] f [8];
    fd = $fopen(TEST_FILE, "r");
    if (fd == 0) begin
      $display("Cannot open test file %s", TEST_FILE);
      errors++;
    end else begin
      num_tests   = 0;
      total_bytes = 0;
      pulse_tests = 0;
      while (!$feof(fd) && num_tests < MAX_TESTS) begin
        rc = $fscanf(fd, "%s", tok);
        if (rc != 1) break;
        if (tok == 64'("#")) begin
          // Skip the rest of a comment line
          do ch = $fgetc(fd); while (ch != 10 && ch != -1);
        end else begin
          rc = $fscanf(fd, "%h %h %h %h %h %h %h %h", f[0], f[1], f[2], f[3],
                       f[4], f[5], f[6], f[7]);
          test_op[num_tests]  = tok;
          test_arg[num_tests] = f;
          total_bytes += packet_bytes(tok);
          if (tok == 64'("msec") || tok == 64'("wdog") || tok == 64'("erase")) pulse_tests++;
          num_tests++;
        end
      end
      $fclose(fd);
      limit_cycles = 40 * total_bytes + 2000 * pulse_tests + 20 * num_tests + 100;
    end
  endtask

  task automatic send_packet(input logic [15:0] port, input logic bcast);
    int gap;
    gap = int'($urandom % 32'd4) + 1;
    repeat (gap) @(posedge clk);
    eth_port      <= port;
    eth_broadcast <= bcast;
    foreach (pkt_q[i]) begin
      eth_valid <= 1'b1;
      eth_data  <= pkt_q[i];
      @(posedge clk);
      check_val("ds_tdata", 32'(ds_tdata), 32'(pkt_q[i]));
    end
    eth_valid <= 1'b0;
    eth_data  <= 8'h00;
    repeat (3) @(posedge clk);
    @(negedge clk);
  endtask

  // Two frames of sync, command word and 63 sample groups each
  task automatic build_data(input logic [7:0] ctrl, input logic cw);
    logic [7:0] b;
    int         fr;
    int         g;
    int         k;
    pkt_q.delete();
    put(PREAMBLE0);
    put(PREAMBLE1);
    put(PKT_DATA);
    put(8'h02);
    put(8'h00);
    put(8'h00);
    put(8'h00);
    put(8'h01);
    for (fr = 0; fr < 2; fr++) begin
      put(SYNC_BYTE);
      put(SYNC_BYTE);
      put(SYNC_BYTE);
      put(ctrl);
      for (k = 0; k < 4; k++) put(8'(fr * 16 + k));
      for (g = 0; g < 63; g++) begin
        for (k = 0; k < 8; k++) begin
          b = 8'((fr * 63 + g) * 8 + k);
          // CW flag rides in the low I byte
          if (k == 5) b[0] = cw;
          put(b);
        end
      end
    end
  endtask

  task automatic build_flash(input logic [31:0] count);
    int i;
    pkt_q.delete();
    put(PREAMBLE0);
    put(PREAMBLE1);
    put(PKT_FLASH);
    put(FLASH_PROGRAM);
    put(count[31:24]);
    put(count[23:16]);
    put(count[15:8]);
    put(count[7:0]);
    for (i = 0; i < 256; i++) put(8'(i * 37 + 11));
  endtask

  task automatic hold_input(input int which, input int n);
    @(posedge clk);
    if (which == 0) msec_pulse <= 1'b1;
    else watchdog_up <= 1'b1;
    repeat (n) @(posedge clk);
    msec_pulse  <= 1'b0;
    watchdog_up <= 1'b0;
    repeat (2) @(posedge clk);
    @(negedge clk);
  endtask

  task automatic run_test(input int t);
    logic [63:0] op;
    logic [31:0] a [8];
    int          err0;
    int          waited;
    int          groups;
    int          exp_user;
    op   = test_op[t];
    a    = test_arg[t];
    err0 = errors;
    base = cnt;
    case (op)
      64'("runstop"): begin
        pkt_q.delete();
        put(a[1][7:0]);
        put(PREAMBLE1);
        put(PKT_RUNSTOP);
        put(a[2][7:0]);
        send_packet(a[0][15:0], 1'b0);
        check_val("run", 32'(run), a[3]);
        check_val("wide_spectrum", 32'(wide_spectrum), a[4]);
      end
      64'("cmd"): begin
        pkt_q.delete();
        put(PREAMBLE0);
        put(PREAMBLE1);
        put(PKT_CMD);
        put(a[2][7:0]);
        put(a[3][31:24]);
        put(a[3][23:16]);
        put(a[3][15:8]);
        put(a[3][7:0]);
        send_packet(a[0][15:0], a[1][0]);
        // Response request is bit 7 of an accepted control byte
        if (a[7] != 0) exp_resprqst = a[2][7];
        check_val("ds_cmd_addr", 32'(ds_cmd_addr), a[4]);
        check_val("ds_cmd_data", ds_cmd_data, a[5]);
        check_val("ds_cmd_is_alt", 32'(ds_cmd_is_alt), a[6]);
        check_val("ds_cmd_resprqst", 32'(ds_cmd_resprqst), 32'(exp_resprqst));
        check_val("ds_cmd_cnt toggles", 32'(cnt[C_CMD] - base[C_CMD]), a[7]);
      end
      64'("data"): begin
        build_data(a[1][7:0], a[2][0]);
        send_packet(a[0][15:0], 1'b0);
        if (a[7] != 0) exp_resprqst = a[1][7];
        check_val("lr_valid beats", 32'(cnt[C_LRV] - base[C_LRV]), a[3]);
        check_val("lr_last pulses", 32'(cnt[C_LRL] - base[C_LRL]), a[4]);
        check_val("iq_valid beats", 32'(cnt[C_IQV] - base[C_IQV]), a[5]);
        check_val("iq_last pulses", 32'(cnt[C_IQL] - base[C_IQL]), a[6]);
        check_val("ds_cmd_cnt toggles", 32'(cnt[C_CMD] - base[C_CMD]), a[7]);
        check_val("ds_cmd_resprqst", 32'(ds_cmd_resprqst), 32'(exp_resprqst));
        // PTT on the first I byte of a group, the previous group's CW flag on the second
        groups = int'(a[5]) / 4;
        if (groups == 2 * SUBFRAMES)
          exp_user = groups * int'(a[1][0]) + int'(prev_cw) + (groups - 1) * int'(a[2][0]);
        else
          exp_user = groups * (int'(a[1][0]) + int'(a[2][0]));
        check_val("iq_user beats", 32'(cnt[C_IQU] - base[C_IQU]), 32'(exp_user));
        prev_cw = a[2][0];
      end
      64'("flash"): begin
        build_flash(a[1]);
        send_packet(a[0][15:0], 1'b0);
        check_val("flash_valid beats", 32'(cnt[C_FLV] - base[C_FLV]), a[2]);
        check_val("flash_last pulses", 32'(cnt[C_FLL] - base[C_FLL]), a[3]);
        check_val("flash_cnt", 32'(flash_cnt), a[4]);
      end
      64'("erase"): begin
        pkt_q.delete();
        put(PREAMBLE0);
        put(PREAMBLE1);
        put(PKT_FLASH);
        put(FLASH_ERASE);
        send_packet(a[0][15:0], 1'b0);
        repeat (a[1]) @(negedge clk);
        check_val("flash_erase", 32'(flash_erase), 32'd1);
        @(posedge clk);
        flash_erase_ack <= 1'b1;
        @(posedge clk);
        flash_erase_ack <= 1'b0;
        waited = 0;
        @(negedge clk);
        while (flash_erase && waited < 16) begin
          @(negedge clk);
          waited++;
        end
        checks++;
        assert (!flash_erase) else begin
          $display("flash_erase stayed high after the acknowledge at %0t ns", $time);
          errors++;
        end
      end
      64'("keyer"): begin
        @(posedge clk);
        cmd_addr <= a[0][CMD_ADDR_W-1:0];
        cmd_data <= a[1];
        cmd_rqst <= 1'b1;
        @(posedge clk);
        cmd_rqst <= 1'b0;
        @(negedge clk);
      end
      64'("msec"): hold_input(0, int'(a[0]));
      64'("wdog"): begin
        hold_input(1, int'(a[0]));
        check_val("run", 32'(run), a[1]);
      end
      64'("disc"): begin
        pkt_q.delete();
        put(PREAMBLE0);
        put(PREAMBLE1);
        put(PKT_DISCOVER);
        put(8'h00);
        send_packet(a[0][15:0], 1'b1);
        check_val("discover_cnt toggles", 32'(cnt[C_DSC] - base[C_DSC]), a[1]);
        check_val("discover_port", 32'(discover_port), a[2]);
      end
      default: begin
        $display("Unknown test operation in line for test %0d", t + 1);
        errors++;
      end
    endcase
    if (errors == err0) $display("Test %0d %0s: ok", t + 1, op);
    else $display("Test %0d %0s: %0d errors", t + 1, op, errors - err0);
  endtask

  initial begin
    void'($urandom(32'h61ac));
    rst             <= 1'b1;
    eth_port        <= 16'h0000;
    eth_broadcast   <= 1'b0;
    eth_valid       <= 1'b0;
    eth_data        <= 8'h00;
    eth_unreachable <= 1'b0;
    watchdog_up     <= 1'b0;
    msec_pulse      <= 1'b0;
    flash_erase_ack <= 1'b0;
    cmd_addr        <= '0;
    cmd_data        <= '0;
    cmd_rqst        <= 1'b0;
    load_tests();
    repeat (5) @(posedge clk);
    rst <= 1'b0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    for (int t = 0; t < num_tests; t++) run_test(t);
    if (num_tests == 0) begin
      $display("No tests found in %s", TEST_FILE);
      errors++;
    end
    $display("Summary: %0d tests, %0d checks, %0d errors", num_tests, checks, errors);
    if (errors == 0) $display("Testbench passed");
    else $display("Testbench failed");
    $finish;
  end

endmodule

//--- bench/hpsdr_ds_props.sv
// Bound concurrent assertions for stream marks and the run register
`timescale 1ns/1ps

module hpsdr_ds_props (
  input logic clk,
  input logic rst,
  input logic eth_valid,
  input logic lr_valid,
  input logic iq_valid,
  input logic flash_valid,
  input logic abort,
  input logic run
);

  // Marks end with the byte stream
  valids_drop: assert property (@(posedge clk) disable iff (rst)
    $fell(eth_valid) |=> !(lr_valid || iq_valid || flash_valid))
    else $error("stream valid still high after eth_valid fell");

  one_stream: assert property (@(posedge clk) disable iff (rst)
    $onehot0({lr_valid, iq_valid, flash_valid}))
    else $error("more than one stream valid high");

  run_abort: assert property (@(posedge clk) disable iff (rst)
    abort |=> !run)
    else $error("run still high the cycle after abort");

endmodule

bind ds_parser hpsdr_ds_props parser_props (
  .clk         (clk),
  .rst         (rst),
  .eth_valid   (eth_valid),
  .lr_valid    (lr_valid),
  .iq_valid    (iq_valid),
  .flash_valid (flash_valid),
  .abort       (1'b0),
  .run         (1'b0)
);

bind link_supervisor hpsdr_ds_props supervisor_props (
  .clk         (clk),
  .rst         (rst),
  .eth_valid   (1'b0),
  .lr_valid    (1'b0),
  .iq_valid    (1'b0),
  .flash_valid (1'b0),
  .abort       (sup.abort),
  .run         (run)
);

//--- design/hpsdr_ds_top.sv
// Downstream unpacker top level with parser, command assembler and link supervisor
`timescale 1ns/1ps

module hpsdr_ds_top (
  input  logic                              clk,
  input  logic                              rst,
  input  logic [15:0]                       eth_port,
  input  logic                              eth_broadcast,
  input  logic                              eth_valid,
  input  logic [7:0]                        eth_data,
  input  logic                              eth_unreachable,
  input  logic                              watchdog_up,
  input  logic                              msec_pulse,
  input  logic                              flash_erase_ack,
  input  logic [hpsdr_pkg::CMD_ADDR_W-1:0]  cmd_addr,
  input  logic [hpsdr_pkg::CMD_DATA_W-1:0]  cmd_data,
  input  logic                              cmd_rqst,
  output logic                              run,
  output logic                              wide_spectrum,
  output logic                              discover_port,
  output logic                              discover_cnt,
  output logic [hpsdr_pkg::CMD_ADDR_W-1:0]  ds_cmd_addr,
  output logic [hpsdr_pkg::CMD_DATA_W-1:0]  ds_cmd_data,
  output logic                              ds_cmd_cnt,
  output logic                              ds_cmd_resprqst,
  output logic                              ds_cmd_is_alt,
  output logic [7:0]                        ds_tdata,
  output logic                              iq_valid,
  output logic                              iq_last,
  output logic                              iq_user,
  output logic                              lr_valid,
  output logic                              lr_last,
  output logic                              flash_valid,
  output logic                              flash_last,
  output logic [hpsdr_pkg::FLASH_CNT_W-1:0] flash_cnt,
  output logic                              flash_erase
);

  cmd_load_if   cmd_bus ();
  supervisor_if sup_bus ();

  logic keyer_internal;

  // Streams share the raw byte lane
  assign ds_tdata = eth_data;

  ds_parser parser0 (
    .clk             (clk),
    .rst             (rst),
    .eth_port        (eth_port),
    .eth_broadcast   (eth_broadcast),
    .eth_valid       (eth_valid),
    .eth_data        (eth_data),
    .flash_erase_ack (flash_erase_ack),
    .cmd             (cmd_bus.parser),
    .sup             (sup_bus.parser),
    .discover_port   (discover_port),
    .discover_cnt    (discover_cnt),
    .lr_valid        (lr_valid),
    .lr_last         (lr_last),
    .iq_valid        (iq_valid),
    .iq_last         (iq_last),
    .iq_user         (iq_user),
    .flash_valid     (flash_valid),
    .flash_last      (flash_last),
    .flash_cnt       (flash_cnt),
    .flash_erase     (flash_erase)
  );

  cmd_assembler asm0 (
    .clk             (clk),
    .rst             (rst),
    .cmd             (cmd_bus.assembler),
    .cmd_addr        (cmd_addr),
    .cmd_data        (cmd_data),
    .cmd_rqst        (cmd_rqst),
    .ds_cmd_addr     (ds_cmd_addr),
    .ds_cmd_data     (ds_cmd_data),
    .ds_cmd_cnt      (ds_cmd_cnt),
    .ds_cmd_resprqst (ds_cmd_resprqst),
    .ds_cmd_is_alt   (ds_cmd_is_alt),
    .keyer_internal  (keyer_internal)
  );

  link_supervisor sup0 (
    .clk             (clk),
    .rst             (rst),
    .eth_unreachable (eth_unreachable),
    .watchdog_up     (watchdog_up),
    .msec_pulse      (msec_pulse),
    .ptt             (cmd_bus.ptt),
    .keyer_internal  (keyer_internal),
    .sup             (sup_bus.supervisor),
    .run             (run),
    .wide_spectrum   (wide_spectrum)
  );

endmodule

//--- design/link_supervisor.sv
// Run and wide-spectrum registers, packet watchdog and CW hang timer
`timescale 1ns/1ps

module link_supervisor (
  input  logic               clk,
  input  logic               rst,
  input  logic               eth_unreachable,
  input  logic               watchdog_up,
  input  logic               msec_pulse,
  input  logic               ptt,
  input  logic               keyer_internal,
  supervisor_if.supervisor   sup,
  output logic               run,
  output logic               wide_spectrum
);
  import hpsdr_pkg::*;

  logic [WATCHDOG_W-1:0] watchdog_cnt;
  logic [HANG_W-1:0]     hang_cnt;
  logic                  hang_active;
  logic                  cw_event;

  assign sup.abort     = eth_unreachable | (&watchdog_cnt);
  assign hang_active   = |hang_cnt;
  assign sup.iq_enable = hang_active | ptt;
  // Only a locally keyed CW element holds I/Q open
  assign cw_event      = sup.cw_load & sup.cw_bit & keyer_internal & ~ptt;

  always_ff @(posedge clk) begin
    if (rst || sup.abort) begin
      run           <= 1'b0;
      wide_spectrum <= 1'b0;
    end else if (sup.runstop_load) begin
      run           <= sup.runstop_bits[0];
      wide_spectrum <= sup.runstop_bits[1];
    end
  end

  // Counts up while running, data packets reset it
  always_ff @(posedge clk) begin
    if (rst || !run || sup.pkt_start) watchdog_cnt <= '0;
    else if (watchdog_up) watchdog_cnt <= watchdog_cnt + 1'b1;
  end

  always_ff @(posedge clk) begin
    if (rst) hang_cnt <= '0;
    else if (cw_event) hang_cnt <= HANG_W'(CW_HANG_MS);
    else if (msec_pulse && hang_active) hang_cnt <= hang_cnt - 1'b1;
  end

endmodule

//--- design/cmd_assembler.sv
// Command word assembly from byte strobes and upstream keyer-enable snoop
`timescale 1ns/1ps

module cmd_assembler (
  input  logic                             clk,
  input  logic                             rst,
  cmd_load_if.assembler                    cmd,
  input  logic [hpsdr_pkg::CMD_ADDR_W-1:0] cmd_addr,
  input  logic [hpsdr_pkg::CMD_DATA_W-1:0] cmd_data,
  input  logic                             cmd_rqst,
  output logic [hpsdr_pkg::CMD_ADDR_W-1:0] ds_cmd_addr,
  output logic [hpsdr_pkg::CMD_DATA_W-1:0] ds_cmd_data,
  output logic                             ds_cmd_cnt,
  output logic                             ds_cmd_resprqst,
  output logic                             ds_cmd_is_alt,
  output logic                             keyer_internal
);
  import hpsdr_pkg::*;

  logic                  stage_resprqst;
  logic [CMD_ADDR_W-1:0] stage_addr;
  logic [CMD_DATA_W-1:8] stage_data;
  logic                  ptt_q;

  assign cmd.ptt = ptt_q;

  // Staged fields taken byte by byte
  always_ff @(posedge clk) begin
    if (cmd.ctrl_load) begin
      stage_resprqst <= cmd.data_byte[7];
      stage_addr     <= cmd.data_byte[6:1];
    end
    if (cmd.data_load && cmd.data_sel != 2'd0)
      stage_data[{cmd.data_sel, 3'b000} +: 8] <= cmd.data_byte;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      ptt_q           <= 1'b0;
      ds_cmd_addr     <= '0;
      ds_cmd_data     <= '0;
      ds_cmd_cnt      <= 1'b0;
      ds_cmd_resprqst <= 1'b0;
      ds_cmd_is_alt   <= 1'b0;
    end else begin
      if (cmd.ctrl_load) ptt_q <= cmd.data_byte[0];
      // Low lane arrives with the commit strobe itself
      if (cmd.commit) begin
        ds_cmd_addr     <= stage_addr;
        ds_cmd_data     <= {stage_data[CMD_DATA_W-1:8], cmd.data_byte};
        ds_cmd_resprqst <= stage_resprqst;
        ds_cmd_is_alt   <= cmd.alt;
        ds_cmd_cnt      <= ~ds_cmd_cnt;
      end
    end
  end

  // Keyer location from the upstream command bus
  always_ff @(posedge clk) begin
    if (rst) keyer_internal <= 1'b0;
    else if (cmd_rqst && cmd_addr == KEYER_CFG_ADDR) keyer_internal <= cmd_data[KEYER_CFG_BIT];
  end

endmodule

//--- design/ds_parser.sv
// Downstream packet parser FSM driving stream marks, command strobes and supervisor events
`timescale 1ns/1ps

module ds_parser (
  input  logic                              clk,
  input  logic                              rst,
  input  logic [15:0]                       eth_port,
  input  logic                              eth_broadcast,
  input  logic                              eth_valid,
  input  logic [7:0]                        eth_data,
  input  logic                              flash_erase_ack,
  cmd_load_if.parser                        cmd,
  supervisor_if.parser                      sup,
  output logic                              discover_port,
  output logic                              discover_cnt,
  output logic                              lr_valid,
  output logic                              lr_last,
  output logic                              iq_valid,
  output logic                              iq_last,
  output logic                              iq_user,
  output logic                              flash_valid,
  output logic                              flash_last,
  output logic [hpsdr_pkg::FLASH_CNT_W-1:0] flash_cnt,
  output logic                              flash_erase
);
  import hpsdr_pkg::*;

  parser_state_e          state;
  parser_state_e          state_next;
  // Group count in [5:0], second-frame flag in [6]; flash beat count uses all 8
  logic [7:0]             pushcnt;
  logic [7:0]             pushcnt_next;
  logic [FLASH_CNT_W-1:0] flash_cnt_next;
  logic                   discover_port_next;
  logic                   discover_cnt_next;
  logic                   cw_bit_q;
  logic                   cw_bit_next;
  logic                   port_ok;

  assign port_ok          = (eth_port[15:1] == HPSDR_PORT_BASE);
  assign cmd.data_byte    = eth_data;
  assign cmd.alt          = eth_port[0];
  assign sup.runstop_bits = eth_data[1:0];
  assign sup.cw_bit       = cw_bit_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      state         <= S_START;
      pushcnt       <= 8'h00;
      flash_cnt     <= '0;
      discover_port <= 1'b0;
      discover_cnt  <= 1'b0;
      cw_bit_q      <= 1'b0;
    end else begin
      state         <= sup.abort ? S_START : state_next;
      pushcnt       <= pushcnt_next;
      flash_cnt     <= flash_cnt_next;
      discover_port <= discover_port_next;
      discover_cnt  <= discover_cnt_next;
      cw_bit_q      <= cw_bit_next;
    end
  end

  always_comb begin
    state_next         = S_START;
    pushcnt_next       = pushcnt;
    flash_cnt_next     = flash_cnt;
    discover_port_next = discover_port;
    discover_cnt_next  = discover_cnt;
    cw_bit_next        = cw_bit_q;
    cmd.ctrl_load      = 1'b0;
    cmd.data_load      = 1'b0;
    cmd.data_sel       = 2'd0;
    cmd.commit         = 1'b0;
    sup.runstop_load   = 1'b0;
    sup.pkt_start      = 1'b0;
    sup.cw_load        = 1'b0;
    lr_valid           = 1'b0;
    lr_last            = 1'b0;
    iq_valid           = 1'b0;
    iq_last            = 1'b0;
    iq_user            = 1'b0;
    flash_valid        = 1'b0;
    flash_last         = 1'b0;
    flash_erase        = 1'b0;

    // Erase wait outlives the packet, everything else needs a live byte
    if (eth_valid || state == S_FLASH_ERASE) begin
      case (state)
        S_START: begin
          if (eth_data == PREAMBLE0 && port_ok) state_next = S_PREAMBLE;
        end
        S_PREAMBLE: begin
          if (eth_data == PREAMBLE1 && port_ok) state_next = S_DECODE;
        end
        S_DECODE: begin
          if (eth_data == PKT_DATA) state_next = S_ENDPOINT;
          else if (eth_data == PKT_RUNSTOP) state_next = S_RUNSTOP;
          else if (eth_data == PKT_DISCOVER) state_next = S_DISCOVERY;
          else if (eth_data == PKT_FLASH) state_next = S_FLASH_DECODE;
          else if (eth_data == PKT_CMD && eth_port[0] && !eth_broadcast)
            state_next = S_CMDCTRL;
        end
        S_RUNSTOP: sup.runstop_load = 1'b1;
        S_DISCOVERY: begin
          discover_port_next = eth_port[0];
          discover_cnt_next  = ~discover_cnt;
        end
        S_FLASH_DECODE: begin
          pushcnt_next = 8'h00;
          if (eth_data == FLASH_PROGRAM) begin
            state_next = S_FLASH_CNT3;
          end else if (eth_data == FLASH_ERASE) begin
            flash_erase = 1'b1;
            state_next  = S_FLASH_ERASE;
          end
        end
        S_FLASH_CNT3: state_next = S_FLASH_CNT2;
        S_FLASH_CNT2: state_next = S_FLASH_CNT1;
        S_FLASH_CNT1: begin
          flash_cnt_next = {eth_data[FLASH_CNT_W-9:0], flash_cnt[7:0]};
          state_next     = S_FLASH_CNT0;
        end
        S_FLASH_CNT0: begin
          flash_cnt_next = {flash_cnt[FLASH_CNT_W-1:8], eth_data};
          state_next     = S_FLASH_PROG;
        end
        S_FLASH_PROG: begin
          flash_valid  = 1'b1;
          pushcnt_next = pushcnt + 8'h01;
          if (&pushcnt) flash_last = 1'b1;
          else state_next = S_FLASH_PROG;
        end
        S_FLASH_ERASE: begin
          flash_erase = 1'b1;
          if (!flash_erase_ack) state_next = S_FLASH_ERASE;
        end
        S_ENDPOINT: begin
          if (eth_data == 8'h02) state_next = S_SEQNO3;
        end
        S_SEQNO3: state_next = S_SEQNO2;
        S_SEQNO2: state_next = S_SEQNO1;
        S_SEQNO1: state_next = S_SEQNO0;
        S_SEQNO0: begin
          sup.pkt_start = 1'b1;
          pushcnt_next  = 8'h00;
          state_next    = S_SYNC2;
        end
        S_SYNC2: if (eth_data == SYNC_BYTE) state_next = S_SYNC1;
        S_SYNC1: if (eth_data == SYNC_BYTE) state_next = S_SYNC0;
        S_SYNC0: if (eth_data == SYNC_BYTE) state_next = S_CMDCTRL;
        S_CMDCTRL: begin
          cmd.ctrl_load = 1'b1;
          state_next    = S_CMDDATA3;
        end
        S_CMDDATA3: begin
          cmd.data_load = 1'b1;
          cmd.data_sel  = 2'd3;
          state_next    = S_CMDDATA2;
        end
        S_CMDDATA2: begin
          cmd.data_load = 1'b1;
          cmd.data_sel  = 2'd2;
          state_next    = S_CMDDATA1;
        end
        S_CMDDATA1: begin
          cmd.data_load = 1'b1;
          cmd.data_sel  = 2'd1;
          state_next    = S_CMDDATA0;
        end
        S_CMDDATA0: begin
          cmd.data_load = 1'b1;
          cmd.commit    = 1'b1;
          // Command-only packets end here
          state_next    = eth_port[0] ? S_START : S_PUSHL1;
        end
        S_PUSHL1, S_PUSHL0, S_PUSHR1: begin
          lr_valid   = 1'b1;
          state_next = parser_state_e'(state + 6'd1);
        end
        S_PUSHR0: begin
          lr_valid     = 1'b1;
          lr_last      = 1'b1;
          pushcnt_next = {pushcnt[7:6], pushcnt[5:0] + 6'd1};
          state_next   = S_PUSHI1;
        end
        S_PUSHI1: begin
          iq_valid   = sup.iq_enable;
          iq_user    = cmd.ptt;
          state_next = S_PUSHI0;
        end
        S_PUSHI0: begin
          iq_valid    = sup.iq_enable;
          iq_user     = cw_bit_q;
          cw_bit_next = eth_data[0];
          state_next  = S_PUSHQ1;
        end
        S_PUSHQ1: begin
          iq_valid   = sup.iq_enable;
          state_next = S_PUSHQ0;
        end
        S_PUSHQ0: begin
          iq_valid    = sup.iq_enable;
          iq_last     = sup.iq_enable;
          sup.cw_load = 1'b1;
          if (pushcnt[5:0] != SUBFRAMES) begin
            state_next = S_PUSHL1;
          end else if (!pushcnt[6]) begin
            // Second frame of the packet follows its own sync
            pushcnt_next = 8'h40;
            state_next   = S_SYNC2;
          end
        end
        default: state_next = S_START;
      endcase
    end
  end

endmodule

//--- design/hpsdr_ifs.sv
// Command-byte load interface and parser-to-supervisor interface
`timescale 1ns/1ps

interface cmd_load_if;
  logic [7:0] data_byte;
  logic       ctrl_load;
  logic       data_load;
  logic [1:0] data_sel;
  logic       commit;
  logic       alt;
  logic       ptt;

  modport parser (output data_byte, ctrl_load, data_load, data_sel, commit, alt, input ptt);
  modport assembler (input data_byte, ctrl_load, data_load, data_sel, commit, alt, output ptt);
endinterface

interface supervisor_if;
  logic       runstop_load;
  logic [1:0] runstop_bits;
  logic       pkt_start;
  logic       cw_load;
  logic       cw_bit;
  logic       abort;
  logic       iq_enable;

  modport parser (output runstop_load, runstop_bits, pkt_start, cw_load, cw_bit,
                  input abort, iq_enable);
  modport supervisor (input runstop_load, runstop_bits, pkt_start, cw_load, cw_bit,
                      output abort, iq_enable);
endinterface

//--- design/hpsdr_pkg.sv
// Downstream protocol constants, parser state encoding, field widths and timer values
package hpsdr_pkg;

  // Packet framing
  localparam logic [7:0]  PREAMBLE0       = 8'hef;
  localparam logic [7:0]  PREAMBLE1       = 8'hfe;
  localparam logic [7:0]  PKT_DATA        = 8'h01;
  localparam logic [7:0]  PKT_DISCOVER    = 8'h02;
  localparam logic [7:0]  PKT_FLASH       = 8'h03;
  localparam logic [7:0]  PKT_RUNSTOP     = 8'h04;
  localparam logic [7:0]  PKT_CMD         = 8'h05;
  localparam logic [7:0]  SYNC_BYTE       = 8'h7f;
  localparam logic [7:0]  FLASH_PROGRAM   = 8'h01;
  localparam logic [7:0]  FLASH_ERASE     = 8'h02;
  localparam logic [14:0] HPSDR_PORT_BASE = 15'd512;

  // Command word
  localparam int          CMD_ADDR_W      = 6;
  localparam int          CMD_DATA_W      = 32;
  localparam logic [5:0]  KEYER_CFG_ADDR  = 6'h0f;
  localparam int          KEYER_CFG_BIT   = 24;

  // Supervisor timers
  localparam int          WATCHDOG_W      = 10;
  localparam int          CW_HANG_MS      = 500;
  localparam int          HANG_W          = 9;

  localparam int          FLASH_CNT_W     = 14;
  localparam logic [5:0]  SUBFRAMES       = 6'd63;

  typedef enum logic [5:0] {
    S_START         = 6'h00, S_PREAMBLE    = 6'h01, S_DECODE      = 6'h02,
    S_RUNSTOP       = 6'h03, S_DISCOVERY   = 6'h04, S_ENDPOINT    = 6'h05,
    S_SEQNO3        = 6'h06, S_SEQNO2      = 6'h07, S_SEQNO1      = 6'h08,
    S_SEQNO0        = 6'h09, S_SYNC2       = 6'h10, S_SYNC1       = 6'h11,
    S_SYNC0         = 6'h12, S_CMDCTRL     = 6'h13, S_CMDDATA3    = 6'h14,
    S_CMDDATA2      = 6'h15, S_CMDDATA1    = 6'h16, S_CMDDATA0    = 6'h17,
    S_PUSHL1        = 6'h18, S_PUSHL0      = 6'h19, S_PUSHR1      = 6'h1a,
    S_PUSHR0        = 6'h1b, S_PUSHI1      = 6'h1c, S_PUSHI0      = 6'h1d,
    S_PUSHQ1        = 6'h1e, S_PUSHQ0      = 6'h1f, S_FLASH_ERASE = 6'h20,
    S_FLASH_DECODE  = 6'h2a, S_FLASH_CNT3  = 6'h2b, S_FLASH_CNT2  = 6'h2c,
    S_FLASH_CNT1    = 6'h2d, S_FLASH_CNT0  = 6'h2e, S_FLASH_PROG  = 6'h2f
  } parser_state_e;

endpackage
